// ==== sources.f ====
+incdir+test
rtl/ctrl_pkg.sv
rtl/ctrl_fsm.sv
rtl/hazard_unit.sv
rtl/core_ctrl.sv
test/core_ctrl_tb.sv

// ==== test/core_ctrl_tasks.svh ====
// Controller test tasks

`ifndef CORE_CTRL_TASKS_SVH
`define CORE_CTRL_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// stimulus and reference helpers
////////////////////////////////////////////////////////////////////////////

// xorshift32, state lives in the testbench
function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// quiet pipeline, fetch enable is left alone
task automatic idle_inputs();
  dec_flags_i       = '0;
  instr_valid_i     = 1'b0;
  jump_in_dec_i     = BRANCH_NONE;
  jump_in_id_i      = BRANCH_NONE;
  branch_taken_ex_i = 1'b0;
  irq_req_i         = 1'b0;
  irq_id_i          = '0;
  id_ready_i        = 1'b1;
  ex_valid_i        = 1'b0;
  data_req_ex_i     = 1'b0;
  reg_we_i          = '0;
  reg_match_i       = '0;
endtask

function automatic pc_ctrl_t pc_expect(input logic set, input pc_mux_e mux,
                                       input exc_pc_e exc_mux);
  pc_ctrl_t p;
  p.set     = set;
  p.mux     = mux;
  p.exc_mux = exc_mux;
  return p;
endfunction

// synchronous exception, epc from ID and the same code in both cause words
function automatic trap_ctrl_t exc_trap_expect(input logic [CAUSE_W-1:0] code);
  trap_ctrl_t t;
  t                = '0;
  t.csr_save_id    = 1'b1;
  t.csr_save_cause = 1'b1;
  t.exc_done       = 1'b1;
  t.exc_cause.exc  = code;
  t.csr_cause.exc  = code;
  return t;
endfunction

// interrupt taken from IF or from ID
function automatic trap_ctrl_t irq_trap_expect(input logic [IRQ_ID_W-1:0] id,
                                               input logic from_if);
  trap_ctrl_t t;
  t                      = '0;
  t.csr_save_if          = from_if;
  t.csr_save_id          = !from_if;
  t.csr_save_cause       = 1'b1;
  t.exc_done             = 1'b1;
  t.irq_ack              = 1'b1;
  t.exc_cause.irq.is_irq = 1'b0;
  t.exc_cause.irq.id     = id;
  t.csr_cause.irq.is_irq = 1'b1;
  t.csr_cause.irq.id     = id;
  return t;
endfunction

// alu result wins over wb, regfile last
function automatic fw_sel_vec_t fw_expect(input reg_we_t we, input reg_match_t m);
  fw_sel_vec_t sel;
  for (int i = 0; i < NUM_OPERANDS; i++)
  begin
    if (we.alu && m.alu[i])
      sel[i] = SEL_FW_EX;
    else if (we.wb && m.wb[i])
      sel[i] = SEL_FW_WB;
    else
      sel[i] = SEL_REGFILE;
  end
  return sel;
endfunction

function automatic logic load_expect(input logic req, input reg_we_t we, input reg_match_t m);
  return req && we.ex && (|m.ex);
endfunction

// operand a sits in bit 0 of each match vector
function automatic logic jr_expect(input jump_e j, input reg_we_t we, input reg_match_t m);
  return (j == BRANCH_JALR) &&
         ((we.wb && m.wb[0]) || (we.ex && m.ex[0]) || (we.alu && m.alu[0]));
endfunction

////////////////////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////////////////////

// mux only matters with set, exc_mux only for exceptions
task automatic check_pc(input pc_ctrl_t got, input pc_ctrl_t exp, input string what);
  if ((got.set !== exp.set) ||
      (exp.set && (got.mux !== exp.mux)) ||
      (exp.set && (exp.mux == PC_EXCEPTION) && (got.exc_mux !== exp.exc_mux)))
    report_error($sformatf("%s: pc_ctrl %h, expected %h", what, got, exp));
endtask

task automatic check_trap(input trap_ctrl_t got, input trap_ctrl_t exp, input string what);
  if (got !== exp)
    report_error($sformatf("%s: trap_ctrl %h, expected %h", what, got, exp));
endtask

task automatic check_fw(input fw_sel_vec_t got, input fw_sel_vec_t exp, input string what);
  if (got !== exp)
    report_error($sformatf("%s: fw_sel %h, expected %h", what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp)
    report_error($sformatf("%s: %b, expected %b", what, got, exp));
endtask

task automatic check_asleep(input string when);
  check_bit(ctrl_busy_o, 1'b0, {when, " ctrl_busy"});
  check_bit(instr_req_o, 1'b0, {when, " instr_req"});
  check_bit(halt_if_o, 1'b1, {when, " halt_if"});
  check_bit(halt_id_o, 1'b1, {when, " halt_id"});
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_boot();
  check_bit(ctrl_busy_o, 1'b0, "busy after reset");
  check_bit(instr_req_o, 1'b0, "instr_req after reset");
  check_bit(deassert_we_o, 1'b1, "deassert_we after reset");
  check_bit(exc_ack_o, 1'b0, "exc_ack after reset");
  check_bit(halt_if_o, 1'b0, "halt_if after reset");
  check_bit(halt_id_o, 1'b0, "halt_id after reset");
  check_bit(first_fetch_o, 1'b0, "first_fetch after reset");
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), "pc after reset");
  check_trap(trap_ctrl_o, '0, "trap after reset");
  @(negedge clk);
  fetch_enable_i = 1'b1;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), "enable sampled");
  @(negedge clk);
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_BOOT, EXC_PC_IRQ), "boot pc");
  @(negedge clk);
  #1;
  check_bit(first_fetch_o, 1'b1, "first fetch after boot");
  check_bit(instr_req_o, 1'b1, "instr_req in first fetch");
endtask

// pure hazard logic while DECODE sees no valid instruction
task automatic test_forwarding();
  logic [31:0] r;
  repeat (200)
  begin
    @(negedge clk);
    r           = next_random();
    reg_we_i    = r[2:0];
    reg_match_i = r[11:3];
    #1;
    check_fw(fw_sel_o, fw_expect(reg_we_i, reg_match_i), "forwarding");
    check_bit(load_stall_o, load_expect(data_req_ex_i, reg_we_i, reg_match_i), "load_stall");
    check_bit(jr_stall_o, jr_expect(jump_in_dec_i, reg_we_i, reg_match_i), "jr_stall");
    check_bit(deassert_we_o, 1'b1, "deassert_we while idle");
  end
  // load in EX feeding operand c
  @(negedge clk);
  idle_inputs();
  data_req_ex_i  = 1'b1;
  reg_we_i.ex    = 1'b1;
  reg_match_i.ex = 3'b100;
  #1;
  check_bit(load_stall_o, 1'b1, "load use hazard");
  check_bit(deassert_we_o, 1'b1, "load use write kill");
  @(negedge clk);
  idle_inputs();
endtask

task automatic test_jumps();
  // jal with ID stalled, redirect only once
  @(negedge clk);
  instr_valid_i = 1'b1;
  jump_in_dec_i = BRANCH_JAL;
  id_ready_i    = 1'b0;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_JUMP, EXC_PC_IRQ), "jal redirect");
  check_bit(is_decoding_o, 1'b1, "jal decoding");
  check_bit(deassert_we_o, 1'b0, "jal keeps its write");
  repeat (4)
  begin
    @(negedge clk);
    #1;
    check_pc(pc_ctrl_o, pc_expect(1'b0, PC_JUMP, EXC_PC_IRQ), "jal held in ID");
  end
  @(negedge clk);
  id_ready_i = 1'b1;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_JUMP, EXC_PC_IRQ), "jal leaving ID");
  @(negedge clk);
  idle_inputs();

  // jalr waits for its target register
  @(negedge clk);
  instr_valid_i  = 1'b1;
  jump_in_dec_i  = BRANCH_JALR;
  reg_we_i.ex    = 1'b1;
  reg_match_i.ex = 3'b001;
  repeat (3)
  begin
    #1;
    check_bit(jr_stall_o, 1'b1, "jalr hazard");
    check_bit(deassert_we_o, 1'b1, "jalr hazard write kill");
    check_pc(pc_ctrl_o, pc_expect(1'b0, PC_JUMP, EXC_PC_IRQ), "jalr stalled");
    @(negedge clk);
  end
  reg_match_i = '0;
  #1;
  check_bit(jr_stall_o, 1'b0, "jalr hazard cleared");
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_JUMP, EXC_PC_IRQ), "jalr redirect");
  @(negedge clk);
  idle_inputs();

  // taken branch overrides the decode slot
  @(negedge clk);
  instr_valid_i     = 1'b1;
  branch_taken_ex_i = 1'b1;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_BRANCH, EXC_PC_IRQ), "taken branch");
  check_bit(is_decoding_o, 1'b0, "decode under taken branch");
  @(negedge clk);
  idle_inputs();
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BRANCH, EXC_PC_IRQ), "after branch");
endtask

// decode the trap, drain EX for a random time, then check the WB pulse
task automatic run_trap(input dec_flags_t flags, input pc_ctrl_t exp_pc,
                        input trap_ctrl_t exp_trap, input string name);
  int hold;
  hold = 1 + (next_random() % 6);
  @(negedge clk);
  instr_valid_i = 1'b1;
  dec_flags_i   = flags;
  #1;
  check_bit(halt_if_o, 1'b1, {name, " halt_if"});
  check_bit(halt_id_o, 1'b1, {name, " halt_id"});
  // only an illegal instruction loses its register write
  check_bit(deassert_we_o, flags.illegal, {name, " write kill"});
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), {name, " decode"});
  repeat (hold)
  begin
    @(negedge clk);
    #1;
    check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), {name, " EX drain"});
    check_trap(trap_ctrl_o, '0, {name, " EX drain"});
  end
  @(negedge clk);
  ex_valid_i = 1'b1;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), {name, " EX valid"});
  @(negedge clk);
  ex_valid_i = 1'b0;
  #1;
  check_pc(pc_ctrl_o, exp_pc, {name, " WB"});
  check_trap(trap_ctrl_o, exp_trap, {name, " WB"});
  @(negedge clk);
  idle_inputs();
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), {name, " back in decode"});
endtask

task automatic test_traps();
  dec_flags_t f;
  trap_ctrl_t t;
  // mcause 11 is ecall from machine mode, 2 is illegal instruction
  f       = '0;
  f.ecall = 1'b1;
  run_trap(f, pc_expect(1'b1, PC_EXCEPTION, EXC_PC_ECALL), exc_trap_expect(6'd11), "ecall");
  f         = '0;
  f.illegal = 1'b1;
  run_trap(f, pc_expect(1'b1, PC_EXCEPTION, EXC_PC_ILLINSN), exc_trap_expect(6'd2), "illegal");
  f                  = '0;
  f.mret             = 1'b1;
  t                  = '0;
  t.csr_restore_mret = 1'b1;
  run_trap(f, pc_expect(1'b1, PC_ERET, EXC_PC_IRQ), t, "mret");
endtask

task automatic test_interrupt();
  logic [31:0] r;
  r = next_random();
  @(negedge clk);
  instr_valid_i = 1'b1;
  irq_req_i     = 1'b1;
  irq_id_i      = r[IRQ_ID_W-1:0];
  #1;
  check_bit(halt_id_o, 1'b1, "irq halt");
  check_bit(trap_ctrl_o.irq_ack, 1'b0, "irq ack too early");
  @(negedge clk);
  #1;
  check_bit(exc_ack_o, 1'b1, "irq flush ack");
  check_bit(trap_ctrl_o.irq_ack, 1'b0, "irq ack too early");
  @(negedge clk);
  irq_req_i     = 1'b0;
  instr_valid_i = 1'b0;
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_EXCEPTION, EXC_PC_IRQ), "irq taken");
  check_trap(trap_ctrl_o, irq_trap_expect(r[IRQ_ID_W-1:0], 1'b0), "irq taken");
  @(negedge clk);
  idle_inputs();
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), "after irq");
endtask

task automatic test_sleep();
  logic [31:0] r;
  r = next_random();
  @(negedge clk);
  fetch_enable_i  = 1'b0;
  instr_valid_i   = 1'b1;
  dec_flags_i.wfi = 1'b1;
  #1;
  check_bit(halt_if_o, 1'b1, "wfi halt");
  @(negedge clk);
  ex_valid_i = 1'b1;
  @(negedge clk);
  ex_valid_i = 1'b0;
  #1;
  // wfi ends the flush without a redirect
  check_pc(pc_ctrl_o, pc_expect(1'b0, PC_BOOT, EXC_PC_IRQ), "wfi WB");
  check_trap(trap_ctrl_o, '0, "wfi WB");
  @(negedge clk);
  idle_inputs();
  #1;
  check_asleep("entering sleep");
  repeat (3)
  begin
    @(negedge clk);
    #1;
    check_asleep("sleeping");
  end
  @(negedge clk);
  irq_req_i = 1'b1;
  irq_id_i  = r[IRQ_ID_W-1:0];
  #1;
  check_asleep("irq seen");
  @(negedge clk);
  #1;
  check_bit(first_fetch_o, 1'b1, "wake first fetch");
  check_bit(exc_ack_o, 1'b1, "wake irq ack");
  @(negedge clk);
  #1;
  check_pc(pc_ctrl_o, pc_expect(1'b1, PC_EXCEPTION, EXC_PC_IRQ), "irq from IF");
  check_trap(trap_ctrl_o, irq_trap_expect(r[IRQ_ID_W-1:0], 1'b1), "irq from IF");
  @(negedge clk);
  irq_req_i = 1'b0;
  #1;
  check_bit(ctrl_busy_o, 1'b1, "busy after wake");
endtask

`endif

// ==== test/core_ctrl_tb.sv ====
// Pipeline controller testbench

`timescale 1ns/1ns

module core_ctrl_tb;

  import ctrl_pkg::*;

  // the directed tests take roughly 300 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESET_CYCLES   = 5;

  logic clk;
  logic rst_n;

  // DUT inputs, named like the ports so the instance can use .*
  logic                fetch_enable_i;
  dec_flags_t          dec_flags_i;
  logic                instr_valid_i;
  jump_e               jump_in_dec_i;
  jump_e               jump_in_id_i;
  logic                branch_taken_ex_i;
  logic                irq_req_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                id_ready_i;
  logic                ex_valid_i;
  logic                data_req_ex_i;
  reg_we_t             reg_we_i;
  reg_match_t          reg_match_i;

  // DUT outputs
  pc_ctrl_t            pc_ctrl_o;
  trap_ctrl_t          trap_ctrl_o;
  logic                exc_ack_o;
  logic                halt_if_o;
  logic                halt_id_o;
  logic                instr_req_o;
  logic                ctrl_busy_o;
  logic                first_fetch_o;
  logic                is_decoding_o;
  logic                deassert_we_o;
  logic                load_stall_o;
  logic                jr_stall_o;
  fw_sel_vec_t         fw_sel_o;

  int unsigned         cycle_count = 0;
  logic [31:0]         rng_state;

  `include "core_ctrl_tasks.svh"

  core_ctrl dut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // clock and run limit
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // counts every rising edge since time zero
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // error handling
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERR %0t ns: %s", $time, msg);
    abort_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    rng_state      = 32'hca12_a2ae;
    idle_inputs();

    repeat (RESET_CYCLES) @(posedge clk);
    // release on the falling edge like every other input
    @(negedge clk);
    rst_n = 1'b1;
    #1;

    test_boot();
    test_forwarding();
    test_jumps();
    test_traps();
    test_interrupt();
    test_sleep();

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== rtl/core_ctrl.sv ====
// Pipeline controller top level

`timescale 1ns/1ns

module core_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  ctrl_pkg::dec_flags_t          dec_flags_i,
  input  logic                          instr_valid_i,
  input  ctrl_pkg::jump_e               jump_in_dec_i,
  input  ctrl_pkg::jump_e               jump_in_id_i,
  input  logic                          branch_taken_ex_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                          id_ready_i,
  input  logic                          ex_valid_i,
  input  logic                          data_req_ex_i,
  input  ctrl_pkg::reg_we_t             reg_we_i,
  input  ctrl_pkg::reg_match_t          reg_match_i,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::trap_ctrl_t          trap_ctrl_o,
  output logic                          exc_ack_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          instr_req_o,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          deassert_we_o,
  output logic                          load_stall_o,
  output logic                          jr_stall_o,
  output ctrl_pkg::fw_sel_vec_t         fw_sel_o
);

  // shared between the two halves
  logic is_decoding;
  logic jr_stall;

  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .dec_flags_i       (dec_flags_i),
    .instr_valid_i     (instr_valid_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .jump_in_id_i      (jump_in_id_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .irq_req_i         (irq_req_i),
    .irq_id_i          (irq_id_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .jr_stall_i        (jr_stall),
    .pc_ctrl_o         (pc_ctrl_o),
    .trap_ctrl_o       (trap_ctrl_o),
    .exc_ack_o         (exc_ack_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .first_fetch_o     (first_fetch_o),
    .is_decoding_o     (is_decoding)
  );

  hazard_unit u_hazard_unit (
    .is_decoding_i (is_decoding),
    .dec_flags_i   (dec_flags_i),
    .jump_in_dec_i (jump_in_dec_i),
    .data_req_ex_i (data_req_ex_i),
    .reg_we_i      (reg_we_i),
    .reg_match_i   (reg_match_i),
    .deassert_we_o (deassert_we_o),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall),
    .fw_sel_o      (fw_sel_o)
  );

endmodule

// ==== rtl/hazard_unit.sv ====
// Stall and forwarding logic

`timescale 1ns/1ns

module hazard_unit (
  input  logic                  is_decoding_i,
  input  ctrl_pkg::dec_flags_t  dec_flags_i,
  input  ctrl_pkg::jump_e       jump_in_dec_i,
  input  logic                  data_req_ex_i,
  input  ctrl_pkg::reg_we_t     reg_we_i,
  input  ctrl_pkg::reg_match_t  reg_match_i,
  output logic                  deassert_we_o,
  output logic                  load_stall_o,
  output logic                  jr_stall_o,
  output ctrl_pkg::fw_sel_vec_t fw_sel_o
);

  import ctrl_pkg::*;

  logic jalr_in_dec;
  logic op_a_pending;

  ////////////////////////////////////////////////////////////////////////////
  // stalls
  ////////////////////////////////////////////////////////////////////////////

  assign jalr_in_dec = (jump_in_dec_i == BRANCH_JALR);

  // jump target register still being produced somewhere ahead
  assign op_a_pending = (reg_we_i.wb  && reg_match_i.wb[OP_A]) ||
                        (reg_we_i.ex  && reg_match_i.ex[OP_A]) ||
                        (reg_we_i.alu && reg_match_i.alu[OP_A]);

  always_comb
  begin
    // load in EX writes a register that decode reads
    load_stall_o = data_req_ex_i && reg_we_i.ex && (|reg_match_i.ex);

    // jalr target cannot be forwarded to the pc
    jr_stall_o = jalr_in_dec && op_a_pending;

    // kill the write of anything that is not really decoded
    deassert_we_o = !is_decoding_i || dec_flags_i.illegal ||
                    load_stall_o || jr_stall_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // forwarding selects
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NUM_OPERANDS; i++)
    begin
      // youngest producer first
      if (reg_we_i.alu && reg_match_i.alu[i])
        fw_sel_o[i] = SEL_FW_EX;
      else if (reg_we_i.wb && reg_match_i.wb[i])
        fw_sel_o[i] = SEL_FW_WB;
      else
        fw_sel_o[i] = SEL_REGFILE;
    end
  end

  // jr stall is only ever caused by a jalr in decode
  always_comb
  begin
    assert (!jr_stall_o || jump_in_dec_i == BRANCH_JALR)
      else $error("jr stall without jalr in decode");
  end

endmodule

// ==== rtl/ctrl_fsm.sv ====
// Main control state machine

`timescale 1ns/1ns

module ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  ctrl_pkg::dec_flags_t          dec_flags_i,
  input  logic                          instr_valid_i,
  input  ctrl_pkg::jump_e               jump_in_dec_i,
  input  ctrl_pkg::jump_e               jump_in_id_i,
  input  logic                          branch_taken_ex_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                          id_ready_i,
  input  logic                          ex_valid_i,
  input  logic                          jr_stall_i,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::trap_ctrl_t          trap_ctrl_o,
  output logic                          exc_ack_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          instr_req_o,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o
);

  import ctrl_pkg::*;

  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB,
    IRQ_FLUSH,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF
  } ctrl_state_e;

  ctrl_state_e ctrl_fsm_cs;
  ctrl_state_e ctrl_fsm_ns;

  logic jump_done;
  logic jump_done_q;
  logic boot_done;
  logic boot_done_q;
  logic jump_in_dec;
  logic branch_in_id;
  logic trap_in_dec;

  // unconditional jumps are resolved in decode
  assign jump_in_dec  = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
  // conditional branch still waiting to reach EX
  assign branch_in_id = (jump_in_id_i == BRANCH_COND);
  assign trap_in_dec  = dec_flags_i.ecall || dec_flags_i.illegal ||
                        dec_flags_i.mret || dec_flags_i.wfi;

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // defaults, busy and fetching
    ctrl_fsm_ns   = ctrl_fsm_cs;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_ack_o     = 1'b0;
    jump_done     = jump_done_q;
    boot_done     = 1'b0;

    pc_ctrl_o.set     = 1'b0;
    pc_ctrl_o.mux     = PC_BOOT;
    pc_ctrl_o.exc_mux = EXC_PC_IRQ;
    trap_ctrl_o       = '0;

    unique case (ctrl_fsm_cs)
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          ctrl_fsm_ns = BOOT_SET;
      end

      // load the boot address into the fetch stage
      BOOT_SET:
      begin
        pc_ctrl_o.set = 1'b1;
        pc_ctrl_o.mux = PC_BOOT;
        boot_done     = 1'b1;
        ctrl_fsm_ns   = FIRST_FETCH;
      end

      WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      // pipeline is empty, wait for fetch enable or an interrupt
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i)
          // a core that never booted takes the boot vector first
          ctrl_fsm_ns = boot_done_q ? FIRST_FETCH : BOOT_SET;
      end

      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        // stay here while IF misses
        if (id_ready_i)
          ctrl_fsm_ns = DECODE;
        // pipeline is flushed, so the interrupt is taken from IF
        if (irq_req_i)
        begin
          exc_ack_o   = 1'b1;
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          ctrl_fsm_ns = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins, the decode slot is discarded
          pc_ctrl_o.set = 1'b1;
          pc_ctrl_o.mux = PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          // hold the interrupt off while a branch in ID could still redirect
          if (irq_req_i && !branch_in_id)
          begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = IRQ_FLUSH;
          end
          else if (jump_in_dec)
          begin
            pc_ctrl_o.mux = PC_JUMP;
            // one redirect per jump, and only once the jr hazard is gone
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_ctrl_o.set = 1'b1;
              jump_done     = 1'b1;
            end
          end
          else if (trap_in_dec)
          begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = FLUSH_EX;
          end
        end
      end

      // drain EX, the wait depends on the instruction ahead
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          ctrl_fsm_ns = FLUSH_WB;
      end

      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        // decode flags are frozen by the halt
        if (dec_flags_i.ecall)
        begin
          pc_ctrl_o.set                = 1'b1;
          pc_ctrl_o.mux                = PC_EXCEPTION;
          pc_ctrl_o.exc_mux            = EXC_PC_ECALL;
          trap_ctrl_o.csr_save_id      = 1'b1;
          trap_ctrl_o.csr_save_cause   = 1'b1;
          trap_ctrl_o.exc_done         = 1'b1;
          trap_ctrl_o.exc_cause.exc    = EXC_CAUSE_ECALL_MMODE;
          trap_ctrl_o.csr_cause.exc    = EXC_CAUSE_ECALL_MMODE;
        end
        else if (dec_flags_i.illegal)
        begin
          pc_ctrl_o.set                = 1'b1;
          pc_ctrl_o.mux                = PC_EXCEPTION;
          pc_ctrl_o.exc_mux            = EXC_PC_ILLINSN;
          trap_ctrl_o.csr_save_id      = 1'b1;
          trap_ctrl_o.csr_save_cause   = 1'b1;
          trap_ctrl_o.exc_done         = 1'b1;
          trap_ctrl_o.exc_cause.exc    = EXC_CAUSE_ILLEGAL_INSN;
          trap_ctrl_o.csr_cause.exc    = EXC_CAUSE_ILLEGAL_INSN;
        end
        else if (dec_flags_i.mret)
        begin
          pc_ctrl_o.set                = 1'b1;
          pc_ctrl_o.mux                = PC_ERET;
          trap_ctrl_o.csr_restore_mret = 1'b1;
        end
        // wfi only decides between decode and sleep
        ctrl_fsm_ns = fetch_enable_i ? DECODE : WAIT_SLEEP;
      end

      // recheck the request, the enable may have changed meanwhile
      IRQ_FLUSH:
      begin
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        exc_ack_o   = 1'b1;
        ctrl_fsm_ns = irq_req_i ? IRQ_TAKEN_ID : DECODE;
      end

      IRQ_TAKEN_ID, IRQ_TAKEN_IF:
      begin
        pc_ctrl_o.set                 = 1'b1;
        pc_ctrl_o.mux                 = PC_EXCEPTION;
        pc_ctrl_o.exc_mux             = EXC_PC_IRQ;
        trap_ctrl_o.exc_cause.irq.id  = irq_id_i;
        trap_ctrl_o.csr_cause.irq.is_irq = 1'b1;
        trap_ctrl_o.csr_cause.irq.id  = irq_id_i;
        trap_ctrl_o.csr_save_cause    = 1'b1;
        // epc comes from the stage that held the next instruction
        trap_ctrl_o.csr_save_id       = (ctrl_fsm_cs == IRQ_TAKEN_ID);
        trap_ctrl_o.csr_save_if       = (ctrl_fsm_cs == IRQ_TAKEN_IF);
        trap_ctrl_o.exc_done          = 1'b1;
        trap_ctrl_o.irq_ack           = 1'b1;
        ctrl_fsm_ns                   = DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_fsm_cs <= RESET;
      jump_done_q <= 1'b0;
      boot_done_q <= 1'b0;
    end
    else
    begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      boot_done_q <= boot_done_q | boot_done;
      // cleared once the jump leaves decode
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

  // no branch prediction, so taken branches cannot come back to back
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branches back to back");

  assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_fsm_cs == RESET) |-> !$rose(pc_ctrl_o.set))
    else $error("pc_set rose in RESET");

endmodule

// ==== rtl/ctrl_pkg.sv ====
// Pipeline controller definitions

package ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // operands a, b and c of the instruction in decode
  localparam int NUM_OPERANDS = 3;
  localparam int OP_A         = 0;

  localparam int IRQ_ID_W = 5;
  localparam int CAUSE_W  = 6;

  // mcause exception codes
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE  = 6'd11;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // next pc source in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // trap vector offset
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_e;

  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

  // operand source in decode
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  // cause word, msb tells an interrupt from an exception
  typedef union packed {
    struct packed {
      logic                is_irq;
      logic [IRQ_ID_W-1:0] id;
    } irq;
    logic [CAUSE_W-1:0] exc;
  } cause_u;

  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
  } dec_flags_t;

  // destination of a later stage equals a source in decode
  typedef struct packed {
    logic [NUM_OPERANDS-1:0] ex;
    logic [NUM_OPERANDS-1:0] wb;
    logic [NUM_OPERANDS-1:0] alu;
  } reg_match_t;

  typedef struct packed {
    logic ex;
    logic wb;
    logic alu;
  } reg_we_t;

  typedef struct packed {
    logic    set;
    pc_mux_e mux;
    exc_pc_e exc_mux;
  } pc_ctrl_t;

  typedef struct packed {
    logic   csr_save_if;
    logic   csr_save_id;
    logic   csr_save_cause;
    logic   csr_restore_mret;
    cause_u exc_cause;
    cause_u csr_cause;
    logic   exc_done;
    logic   irq_ack;
  } trap_ctrl_t;

  typedef fw_sel_e [NUM_OPERANDS-1:0] fw_sel_vec_t;

endpackage
